/* run.sh */
#!/bin/sh
# Build and run the sequence controller testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
	--top-module seq_tb -f src.f -o seq_sim
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

out=$(./obj_dir/seq_sim +verilator+error+limit+1000)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "All checks passed"; then
	exit 0
fi
exit 1

/* src.f */
verilog/seq_pkg.sv
verilog/ingress_queue.sv
verilog/seq_controller.sv
verilog/activity_profiler.sv
verilog/result_merger.sv
verilog/seq_top.sv
tb/tb_clock.sv
tb/seq_asserts.sv
tb/seq_tb.sv

/* tb/seq_asserts.sv */
`timescale 1ns/10ps

module seq_asserts
	import seq_pkg::*;
(
	input logic      rst,
	input logic      clk,
	input in_beat_t  in_beat,
	input logic      step,
	input logic      res_credit,
	input res_beat_t res_beat
);

	int fill;
	int credits;
	int fail_count = 0;

	// Shadow queue fill and output credits.
	always_ff @(posedge rst or negedge clk)
	begin
		if (!clk)
		begin
			fill    <= 0;
			credits <= int'(OUT_CREDITS);
		end
		else
		begin
			fill    <= fill + int'(in_beat.valid) - int'(step);
			credits <= credits - int'(step) + int'(res_credit);
		end
	end

	//////////////////////////////////////////////////
	// Credit protocol.
	//////////////////////////////////////////////////

	no_full_write: assert property (@(posedge rst) disable iff (!clk)
		in_beat.valid |-> fill < QUEUE_DEPTH)
	else
	begin
		fail_count++;
		$error("Input beat written into a full queue");
	end

	spend_with_credit: assert property (@(posedge rst) disable iff (!clk)
		res_beat.valid |-> $past(credits) > 0)
	else
	begin
		fail_count++;
		$error("Result beat issued without an output credit");
	end

	step_with_data: assert property (@(posedge rst) disable iff (!clk)
		step |-> fill > 0)
	else
	begin
		fail_count++;
		$error("Step raised while the queue is empty");
	end

endmodule

bind seq_top seq_asserts asserts_i (
	.rst        (rst),
	.clk        (clk),
	.in_beat    (in_beat),
	.step       (step),
	.res_credit (res_credit),
	.res_beat   (res_beat)
);

/* tb/seq_tb.sv */
`timescale 1ns/10ps

module seq_tb
	import seq_pkg::*;
();

	localparam int NUM_BEATS = 3000;
	localparam int PHASE_LEN = NUM_BEATS / 3;
	localparam int LIMIT     = int'(SILENCE_LIMIT);
	localparam int OUT_CRED  = int'(OUT_CREDITS);

	typedef struct packed
	{
		out_word_t  y;
		seq_state_e nxt;
	} step_t;

	logic      rst;
	logic      clk;
	in_beat_t  in_beat;
	logic      in_credit;
	res_beat_t res_beat;
	logic      res_credit;

	logic [31:0] seed = 32'd76;
	in_word_t    pending [$];
	in_word_t    next_word;
	seq_state_e  m_state = s1;
	int          m_cnt [NUM_OUTPUTS];
	int          visits [16];
	bit          sil_seen = 0;
	int tx_credits = QUEUE_DEPTH;
	int sent = 0;
	int credit_pulses = 0;
	int received = 0;
	int returned = 0;
	int owed = 0;
	int pause = 0;
	int err_outputs = 0;
	int err_state = 0;
	int err_silent = 0;
	int err_proto = 0;
	int err_cover = 0;

	tb_clock clock_i (.rst(rst), .clk(clk));

	seq_top dut_i (
		.rst        (rst),
		.clk        (clk),
		.in_beat    (in_beat),
		.in_credit  (in_credit),
		.res_beat   (res_beat),
		.res_credit (res_credit)
	);

	function automatic logic [15:0] rand16();
		seed = seed * 32'd1664525 + 32'd1013904223;  // LCG.
		return seed[31:16];
	endfunction

	function automatic int roll(int n);
		return int'(rand16()) % n;
	endfunction

	// Low words, then any words, then x4, x11 and x15 held low.
	function automatic in_word_t make_word(int idx);
		in_word_t w;
		w = rand16();
		if (idx < PHASE_LEN)
			w = w & rand16() & rand16();
		else if (idx >= 2 * PHASE_LEN)
			w = w & ~in_word_t'(16'h4408);
		return w;
	endfunction

	//////////////////////////////////////////////////
	// Reference table.
	//////////////////////////////////////////////////

	function automatic step_t tr(int a, seq_state_e nxt, int b = 0);
		step_t r;
		r.y   = '0;
		r.nxt = nxt;
		if (a > 0)
			r.y = r.y | (out_word_t'(1) << (a - 1));
		if (b > 0)
			r.y = r.y | (out_word_t'(1) << (b - 1));
		return r;
	endfunction

	function automatic step_t table_step(seq_state_e s, in_word_t w);
		logic [16:1] x;
		step_t       r;
		x = w;
		case (s)
			s1:  r = x[9] ? (x[16] ? (x[8] ? tr(10, s2) : x[5] ? tr(7, s2) : tr(4, s3))
					: tr(5, s4))
				: x[10] ? (x[5] ? tr(1, s5) : tr(4, s3))
				: x[1] ? tr(1, s6) : x[2] ? tr(3, s7) : tr(2, s8);
			s2:  r = tr(8, s9);
			s3:  r = x[7] ? (x[9] ? (x[8] ? tr(3, s7) : tr(0, s3)) : tr(0, s1))
				: x[6] ? (x[4] ? (x[13] ? tr(1, s10, 11) : tr(3, s7)) : tr(0, s3))
				: tr(0, s1);
			s4:  r = x[1] ? tr(1, s6) : x[2] ? tr(3, s7) : tr(2, s8);
			s5:  r = x[12] ? (x[15] ? tr(6, s11) : tr(0, s5)) : x[3] ? tr(0, s1) : tr(4, s3);
			s6:  r = x[2] ? tr(3, s7) : tr(2, s8);
			s7:  r = (x[16] && x[14]) ? (x[5] ? tr(7, s2) : tr(4, s3))
				: x[11] ? ((x[16] || x[5]) ? tr(1, s5) : tr(4, s3))
				: x[3] ? tr(0, s1) : tr(4, s3);
			s8:  r = x[11] ? tr(1, s5) : x[3] ? tr(0, s1) : tr(4, s3);
			s9:  r = x[4] ? tr(9, s1) : tr(0, s9);
			s10: r = x[15] ? tr(6, s11) : tr(0, s10);
			s11: r = tr(10, s2);
			default: r = tr(0, s1);
		endcase
		return r;
	endfunction

	task automatic compare_outputs(out_word_t exp, out_word_t act);
		if (act !== exp)
		begin
			$display("FAILED at %0t: res_beat.data.outputs expected %h, got %h", $time, exp, act);
			err_outputs++;
		end
	endtask

	task automatic compare_state(seq_state_e exp, seq_state_e act);
		if (act !== exp)
		begin
			$display("FAILED at %0t: res_beat.data.state expected s%0d, got s%0d", $time, exp, act);
			err_state++;
		end
	endtask

	task automatic compare_silent(logic [NUM_OUTPUTS-1:0] exp, logic [NUM_OUTPUTS-1:0] act);
		if (act !== exp)
		begin
			$display("FAILED at %0t: res_beat.data.silent expected %h, got %h", $time, exp, act);
			err_silent++;
		end
	endtask

	// Steps the model with the oldest word and checks one record.
	task automatic check_result(result_t got);
		step_t                  s;
		logic [NUM_OUTPUTS-1:0] sil;
		if (pending.size() == 0)
		begin
			$display("A result arrived with no input word left to explain it");
			err_proto++;
			return;
		end
		s       = table_step(m_state, pending.pop_front());
		m_state = s.nxt;
		visits[s.nxt]++;
		sil = '0;
		for (int k = 0; k < NUM_OUTPUTS; k++)
		begin
			if (s.y[k])
				m_cnt[k] = 0;
			else if (m_cnt[k] < LIMIT)
				m_cnt[k]++;
			sil[k] = (m_cnt[k] == LIMIT);
		end
		if (sil != '0)
			sil_seen = 1;
		compare_outputs(s.y, got.outputs);
		compare_state(s.nxt, got.state);
		compare_silent(sil, got.silent);
	endtask

	initial
	begin
		in_beat    = '0;
		res_credit = 1'b0;
	end

	//////////////////////////////////////////////////
	// Sender, receiver and credit return.
	//////////////////////////////////////////////////

	always @(posedge rst)
	begin
		if (clk)
		begin
			if (res_beat.valid)
			begin
				received++;
				owed++;
				if (received > OUT_CRED + returned)
				begin
					$display("More results arrived than output credits were given");
					err_proto++;
				end
				check_result(res_beat.data);
			end
			if (in_credit)
			begin
				tx_credits++;
				credit_pulses++;
				if (tx_credits > QUEUE_DEPTH)
				begin
					$display("The queue returned more input credits than beats were sent");
					err_proto++;
				end
			end
			if (sent < NUM_BEATS && tx_credits > 0 && roll(4) != 0)
			begin
				next_word = make_word(sent);
				in_beat.valid <= 1'b1;
				in_beat.word  <= next_word;
				pending.push_back(next_word);
				tx_credits--;
				sent++;
			end
			else
				in_beat <= '0;
			// Long pauses force back-pressure.
			if (pause > 0)
			begin
				pause--;
				res_credit <= 1'b0;
			end
			else if (roll(128) == 0)
			begin
				pause = 40 + roll(60);
				res_credit <= 1'b0;
			end
			else if (owed > 0 && roll(4) != 0)
			begin
				owed--;
				returned++;
				res_credit <= 1'b1;
			end
			else
				res_credit <= 1'b0;
		end
	end

	initial
	begin
		wait (received == NUM_BEATS);
		repeat (10) @(posedge rst);
		if (credit_pulses != sent || pending.size() != 0)
		begin
			$display("Input credits returned (%0d) do not match beats sent (%0d)",
				credit_pulses, sent);
			err_proto++;
		end
		if (visits[s2] == 0 || visits[s4] == 0 || visits[s9] == 0 ||
			visits[s10] == 0 || visits[s11] == 0)
		begin
			$display("The stimulus never reached one of s2, s4, s9, s10 or s11");
			err_cover++;
		end
		if (!sil_seen)
		begin
			$display("No output line ever went silent");
			err_cover++;
		end
		err_proto += dut_i.asserts_i.fail_count;
		$display("Errors: outputs %0d, state %0d, silent %0d, protocol %0d, coverage %0d",
			err_outputs, err_state, err_silent, err_proto, err_cover);
		if (err_outputs + err_state + err_silent + err_proto + err_cover == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

	// Watchdog.
	initial
	begin
		#(4 * 20 * NUM_BEATS);
		$display("Timeout: only %0d of %0d results arrived", received, NUM_BEATS);
		$display("Checks failed");
		$finish;
	end

endmodule

/* tb/tb_clock.sv */
`timescale 1ns/10ps

module tb_clock
(
	output logic rst,
	output logic clk
);

	localparam int RESET_CYCLES = 8;

	// 4 ns period.
	initial
	begin
		rst = 1'b0;
		forever
			#2 rst = ~rst;
	end

	// Start high so the reset gets a real falling edge.
	initial
	begin
		clk = 1'b1;
		#1 clk = 1'b0;
		repeat (RESET_CYCLES) @(posedge rst);
		clk <= 1'b1;
	end

endmodule

/* verilog/activity_profiler.sv */
`timescale 1ns/10ps

module activity_profiler
	import seq_pkg::*;
(
	input  logic                   rst,
	input  logic                   clk,
	input  out_word_t              y,
	input  logic                   step,
	output logic [NUM_OUTPUTS-1:0] silent
);

	// Steps since each line last fired.
	silence_t cnt [NUM_OUTPUTS];

	//////////////////////////////////////////////////
	// Silence counters.
	//////////////////////////////////////////////////

	always_ff @(posedge rst or negedge clk)
	begin
		if (!clk)
		begin
			for (int k = 0; k < NUM_OUTPUTS; k++)
				cnt[k] <= '0;
		end
		else if (step)
		begin
			for (int k = 0; k < NUM_OUTPUTS; k++)
			begin
				if (y[k])
					cnt[k] <= '0;  // Line fired.
				else if (cnt[k] != SILENCE_LIMIT)
					cnt[k] <= cnt[k] + 1'b1;
			end
		end
	end

	// Flag lines held at the limit.
	always_comb
	begin
		for (int k = 0; k < NUM_OUTPUTS; k++)
			silent[k] = (cnt[k] == SILENCE_LIMIT);
	end

endmodule

/* verilog/ingress_queue.sv */
`timescale 1ns/10ps

module ingress_queue
	import seq_pkg::*;
(
	input  logic     rst,
	input  logic     clk,
	input  in_beat_t in_beat,
	input  logic     pop,
	output in_word_t head,
	output logic     ready,
	output logic     in_credit
);

	in_word_t mem [QUEUE_DEPTH];
	q_ptr_t   wr_ptr;
	q_ptr_t   rd_ptr;
	q_cnt_t   fill;
	logic     push;
	logic     pull;

	assign push      = in_beat.valid;
	assign pull      = pop && ready;
	assign ready     = (fill != '0);
	assign head      = mem[rd_ptr];
	assign in_credit = pull;  // One credit back per pop.

	//////////////////////////////////////////////////
	// Pointers and fill count.
	//////////////////////////////////////////////////

	always_ff @(posedge rst or negedge clk)
	begin
		if (!clk)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill   <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;  // Wraps at depth.
			if (pull)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pull})
				2'b10:   fill <= fill + 1'b1;
				2'b01:   fill <= fill - 1'b1;
				default: fill <= fill;
			endcase
		end
	end

	// Storage.
	always_ff @(posedge rst)
	begin
		if (push)
			mem[wr_ptr] <= in_beat.word;
	end

endmodule

/* verilog/result_merger.sv */
`timescale 1ns/10ps

module result_merger
	import seq_pkg::*;
(
	input  logic                   rst,
	input  logic                   clk,
	input  logic                   ready,
	input  out_word_t              y,
	input  seq_state_e             next_state,
	input  logic [NUM_OUTPUTS-1:0] silent,
	input  logic                   res_credit,
	output logic                   step,
	output res_beat_t              res_beat
);

	credit_t    credits;
	logic       res_valid;
	out_word_t  res_y;
	seq_state_e res_state;

	// Credit is taken when the step is scheduled.
	assign step = ready && (credits != '0);

	//////////////////////////////////////////////////
	// Output credits and beat valid.
	//////////////////////////////////////////////////

	always_ff @(posedge rst or negedge clk)
	begin
		if (!clk)
		begin
			credits   <= OUT_CREDITS;
			res_valid <= 1'b0;
		end
		else
		begin
			res_valid <= step;
			case ({step, res_credit})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits;  // Spend and return cancel.
			endcase
		end
	end

	always_ff @(posedge rst)
	begin
		if (step)
		begin
			res_y     <= y;
			res_state <= next_state;
		end
	end

	// Mask already holds the post-step counters here.
	assign res_beat.valid        = res_valid;
	assign res_beat.data.outputs = res_y;
	assign res_beat.data.state   = res_state;
	assign res_beat.data.silent  = silent;

endmodule

/* verilog/seq_controller.sv */
`timescale 1ns/10ps

module seq_controller
	import seq_pkg::*;
(
	input  logic       rst,
	input  logic       clk,
	input  in_word_t   x,
	input  logic       step,
	output out_word_t  y,
	output seq_state_e state,
	output seq_state_e next_state
);

	typedef struct packed
	{
		out_word_t  y;
		seq_state_e nxt;
	} trans_t;

	logic [16:1] xs;  // Table numbering.
	trans_t      t;

	// One-hot word for line yk.
	function automatic out_word_t yk(input int k);
		return out_word_t'(1) << (k - 1);
	endfunction

	function automatic trans_t go(input out_word_t fired, input seq_state_e nxt);
		return '{y: fired, nxt: nxt};
	endfunction

	assign xs         = x;
	assign y          = t.y;
	assign next_state = t.nxt;

	always_ff @(posedge rst or negedge clk)
	begin
		if (!clk)
			state <= s1;
		else if (step)
			state <= next_state;
	end

	//////////////////////////////////////////////////
	// Transition table.
	//////////////////////////////////////////////////

	always_comb
	begin
		t = go('0, s1);
		case (state)
			s1:
				if (xs[9] && xs[16] && xs[8])
					t = go(yk(10), s2);
				else if (xs[9] && xs[16] && xs[5])
					t = go(yk(7), s2);
				else if (xs[9] && xs[16])
					t = go(yk(4), s3);
				else if (xs[9])
					t = go(yk(5), s4);
				else if (xs[10] && xs[5])
					t = go(yk(1), s5);
				else if (xs[10])
					t = go(yk(4), s3);
				else if (xs[1])
					t = go(yk(1), s6);
				else if (xs[2])
					t = go(yk(3), s7);
				else
					t = go(yk(2), s8);
			s2:
				t = go(yk(8), s9);
			s3:
				if (xs[7] && xs[9] && xs[8])
					t = go(yk(3), s7);
				else if (xs[7] && xs[9])
					t = go('0, s3);
				else if (xs[7])
					t = go('0, s1);
				else if (xs[6] && xs[4] && xs[13])
					t = go(yk(1) | yk(11), s10);  // Two lines fire here.
				else if (xs[6] && xs[4])
					t = go(yk(3), s7);
				else if (xs[6])
					t = go('0, s3);
				else
					t = go('0, s1);
			s4:
				if (xs[1])
					t = go(yk(1), s6);
				else if (xs[2])
					t = go(yk(3), s7);
				else
					t = go(yk(2), s8);
			s5:
				if (xs[12] && xs[15])
					t = go(yk(6), s11);
				else if (xs[12])
					t = go('0, s5);
				else if (xs[3])
					t = go('0, s1);
				else
					t = go(yk(4), s3);
			s6:
				if (xs[2])
					t = go(yk(3), s7);
				else
					t = go(yk(2), s8);
			s7:
				// With ~x14 the x16 split only matters when x11 and ~x5.
				if (xs[16] && xs[14] && xs[5])
					t = go(yk(7), s2);
				else if (xs[16] && xs[14])
					t = go(yk(4), s3);
				else if (xs[11] && (xs[16] || xs[5]))
					t = go(yk(1), s5);
				else if (xs[11])
					t = go(yk(4), s3);
				else if (xs[3])
					t = go('0, s1);
				else
					t = go(yk(4), s3);
			s8:
				if (xs[11])
					t = go(yk(1), s5);
				else if (xs[3])
					t = go('0, s1);
				else
					t = go(yk(4), s3);
			s9:
				if (xs[4])
					t = go(yk(9), s1);
				else
					t = go('0, s9);  // Wait for x4.
			s10:
				if (xs[15])
					t = go(yk(6), s11);
				else
					t = go('0, s10);
			s11:
				t = go(yk(10), s2);
			default:
				t = go('0, s1);
		endcase
	end

endmodule

/* verilog/seq_pkg.sv */
package seq_pkg;

	//////////////////////////////////////////////////
	// Widths fixed by the transition table.
	//////////////////////////////////////////////////

	localparam int NUM_INPUTS  = 16;
	localparam int NUM_OUTPUTS = 11;
	localparam int QUEUE_DEPTH = 4;  // Also the upstream sender's starting credits.

	typedef logic [NUM_INPUTS-1:0]         in_word_t;   // Bit k-1 is xk.
	typedef logic [NUM_OUTPUTS-1:0]        out_word_t;  // Bit k-1 is yk.
	typedef logic [4:0]                    silence_t;
	typedef logic [$clog2(QUEUE_DEPTH)-1:0] q_ptr_t;
	typedef logic [$clog2(QUEUE_DEPTH):0]   q_cnt_t;
	typedef logic [1:0]                    credit_t;

	localparam credit_t  OUT_CREDITS   = 2'd2;
	localparam silence_t SILENCE_LIMIT = 5'd16;  // Steps without firing.

	typedef enum logic [3:0]
	{
		s1  = 4'd1,
		s2  = 4'd2,
		s3  = 4'd3,
		s4  = 4'd4,
		s5  = 4'd5,
		s6  = 4'd6,
		s7  = 4'd7,
		s8  = 4'd8,
		s9  = 4'd9,
		s10 = 4'd10,
		s11 = 4'd11
	} seq_state_e;

	//////////////////////////////////////////////////
	// Beats and records.
	//////////////////////////////////////////////////

	typedef struct packed
	{
		logic     valid;
		in_word_t word;
	} in_beat_t;

	// One record per step.
	typedef struct packed
	{
		out_word_t              outputs;
		seq_state_e             state;   // State after the step.
		logic [NUM_OUTPUTS-1:0] silent;
	} result_t;

	typedef struct packed
	{
		logic    valid;
		result_t data;
	} res_beat_t;

endpackage

/* verilog/seq_top.sv */
`timescale 1ns/10ps

module seq_top
	import seq_pkg::*;
(
	input  logic      rst,
	input  logic      clk,
	input  in_beat_t  in_beat,
	output logic      in_credit,
	output res_beat_t res_beat,
	input  logic      res_credit
);

	in_word_t               head;
	logic                   ready;
	logic                   step;
	out_word_t              y;
	seq_state_e             next_state;
	logic [NUM_OUTPUTS-1:0] silent;

	ingress_queue queue_i (
		.rst       (rst),
		.clk       (clk),
		.in_beat   (in_beat),
		.pop       (step),
		.head      (head),
		.ready     (ready),
		.in_credit (in_credit)
	);

	// Controller and profiler share the same step.
	seq_controller ctl_i (
		.rst        (rst),
		.clk        (clk),
		.x          (head),
		.step       (step),
		.y          (y),
		.state      (),
		.next_state (next_state)
	);

	activity_profiler prof_i (
		.rst    (rst),
		.clk    (clk),
		.y      (y),
		.step   (step),
		.silent (silent)
	);

	result_merger merge_i (
		.rst        (rst),
		.clk        (clk),
		.ready      (ready),
		.y          (y),
		.next_state (next_state),
		.silent     (silent),
		.res_credit (res_credit),
		.step       (step),
		.res_beat   (res_beat)
	);

endmodule
